// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // ==============================
    // Types
    // ==============================
    typedef logic [31:0] word_t;      // Data, address and instruction word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // Source of an EX operand
    typedef enum logic [1:0] {
        FWD_REG,    // Value read in ID
        FWD_MEM,    // EX/MEM result
        FWD_WB      // MEM/WB writeback value
    } fwd_sel_t;

    // ==============================
    // Primary opcodes
    // ==============================
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_SLTIU = 6'h0b;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    localparam word_t     RESET_PC    = 32'h0000_0000;
    localparam reg_addr_t LINK_REG    = 5'd31;
    localparam word_t     LINK_OFFSET = 32'd8;   // JAL links past itself and the next slot

endpackage

`default_nettype wire

// ==== design/decoder.sv ====
`default_nettype none

module decoder (
    input  wire cpu_pkg::word_t instr,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                mem_to_reg,
    output logic                alu_src_imm,
    output logic                imm_zero_ext,
    output logic                dest_rd,
    output logic                is_shift,
    output logic                is_link,
    output logic                is_branch_eq,
    output logic                is_branch_ne,
    output logic                is_jump,
    output logic                is_jump_reg,
    output cpu_pkg::alu_op_t    alu_op
);
    import cpu_pkg::*;

    opcode_t op;
    funct_t  fn;

    assign op = instr[31:26];
    assign fn = instr[5:0];

    always_comb begin
        reg_write    = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_to_reg   = 1'b0;
        alu_src_imm  = 1'b0;
        imm_zero_ext = 1'b0;
        dest_rd      = 1'b0;
        is_shift     = 1'b0;
        is_link      = 1'b0;
        is_branch_eq = 1'b0;
        is_branch_ne = 1'b0;
        is_jump      = 1'b0;
        is_jump_reg  = 1'b0;
        alu_op       = ALU_ADD;

        case (op)
            OP_RTYPE: begin
                dest_rd   = 1'b1;
                reg_write = 1'b1;
                case (fn)
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;   // No overflow trap
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLT:          alu_op = ALU_SLT;
                    FN_SLTU:         alu_op = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        is_shift = 1'b1;         // Amount from shamt field
                        alu_op   = (fn == FN_SLL) ? ALU_SLL :
                                   (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_JR: begin
                        reg_write   = 1'b0;
                        is_jump_reg = 1'b1;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                reg_write    = 1'b1;
                alu_src_imm  = 1'b1;
                imm_zero_ext = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
                case (op)
                    OP_SLTI:  alu_op = ALU_SLT;
                    OP_SLTIU: alu_op = ALU_SLTU;   // Unsigned compare of the sign-extended imm
                    OP_ANDI:  alu_op = ALU_AND;
                    OP_ORI:   alu_op = ALU_OR;
                    OP_XORI:  alu_op = ALU_XOR;
                    OP_LUI:   alu_op = ALU_LUI;
                    default:  alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                mem_to_reg  = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_SW: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_BEQ: is_branch_eq = 1'b1;
            OP_BNE: is_branch_ne = 1'b1;
            OP_J:   is_jump = 1'b1;
            OP_JAL: begin
                is_jump   = 1'b1;
                is_link   = 1'b1;
                reg_write = 1'b1;
            end
            default: ;   // Unknown opcode runs as a no-op
        endcase

        // All-zero word is the canonical NOP
        if (instr == '0) begin
            reg_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`default_nettype none

module regfile (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cpu_pkg::reg_addr_t raddr1,
    input  wire cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t          rdata1,
    output cpu_pkg::word_t          rdata2,
    input  wire                     we,
    input  wire cpu_pkg::reg_addr_t waddr,
    input  wire cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t regs [1:31];   // r0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write shows up on the read ports
    assign rdata1 = (raddr1 == '0)                ? '0    :
                    (we && waddr == raddr1)        ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0)                ? '0    :
                    (we && waddr == raddr2)        ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    output cpu_pkg::word_t        y
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = a[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_NOR:  y = ~(a | b);
            ALU_SLT:  y = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: y = {31'd0, a < b};
            ALU_SLL:  y = b << shamt;
            ALU_SRL:  y = b >> shamt;
            ALU_SRA:  y = word_t'($signed(b) >>> shamt);
            ALU_LUI:  y = {b[15:0], 16'h0000};
            default:  y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
    input  wire cpu_pkg::reg_addr_t id_rs,
    input  wire cpu_pkg::reg_addr_t id_rt,
    input  wire                     id_uses_branch_operands,
    input  wire cpu_pkg::reg_addr_t ex_rs,
    input  wire cpu_pkg::reg_addr_t ex_rt,
    input  wire cpu_pkg::reg_addr_t ex_dst,
    input  wire                     ex_reg_write,
    input  wire                     ex_mem_read,
    input  wire cpu_pkg::reg_addr_t mem_dst,
    input  wire                     mem_reg_write,
    input  wire                     mem_mem_read,
    input  wire cpu_pkg::reg_addr_t wb_dst,
    input  wire                     wb_reg_write,
    output cpu_pkg::fwd_sel_t       fwd_a,
    output cpu_pkg::fwd_sel_t       fwd_b,
    output logic                    stall
);
    import cpu_pkg::*;

    logic load_use;
    logic branch_wait;

    // Writer with a live, nonzero destination equal to src
    function automatic logic hit(input reg_addr_t dst, input logic wr, input reg_addr_t src);
        return wr && (dst != '0) && (dst == src);
    endfunction

    // ==============================
    // EX operand forwarding
    // ==============================
    always_comb begin
        fwd_a = FWD_REG;
        fwd_b = FWD_REG;
        if (hit(mem_dst, mem_reg_write, ex_rs)) begin
            fwd_a = FWD_MEM;           // Newest value wins
        end else if (hit(wb_dst, wb_reg_write, ex_rs)) begin
            fwd_a = FWD_WB;
        end
        if (hit(mem_dst, mem_reg_write, ex_rt)) begin
            fwd_b = FWD_MEM;
        end else if (hit(wb_dst, wb_reg_write, ex_rt)) begin
            fwd_b = FWD_WB;
        end
    end

    // Load data is not ready until WB
    assign load_use = hit(ex_dst, ex_mem_read, id_rs) || hit(ex_dst, ex_mem_read, id_rt);

    // Branch and JR compare in ID, so they wait for EX results and MEM loads
    assign branch_wait = id_uses_branch_operands &&
                         (hit(ex_dst, ex_reg_write, id_rs) || hit(ex_dst, ex_reg_write, id_rt) ||
                          hit(mem_dst, mem_mem_read, id_rs) || hit(mem_dst, mem_mem_read, id_rt));

    assign stall = load_use || branch_wait;

endmodule

`default_nettype wire

// ==== design/cpu_core.sv ====
`default_nettype none

module cpu_core (
    input  wire                 clk,
    input  wire                 rst,
    input  wire cpu_pkg::word_t imem_rdata,
    output cpu_pkg::word_t      imem_addr,
    input  wire cpu_pkg::word_t dmem_rdata,
    output cpu_pkg::word_t      dmem_addr,
    output cpu_pkg::word_t      dmem_wdata,
    output logic                dmem_we
);
    import cpu_pkg::*;

    word_t     pc, pc_next;
    logic      stall, redirect, branch_taken;
    word_t     if_id_pc, if_id_instr;

    // ID stage
    reg_addr_t id_rs, id_rt, id_dst;
    word_t     id_imm, id_pc4, id_a, id_b, rf_rdata1, rf_rdata2;
    word_t     branch_target, jump_target;
    logic      id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg;
    logic      id_alu_src_imm, id_imm_zero_ext, id_dest_rd, id_is_shift, id_is_link;
    logic      id_is_branch_eq, id_is_branch_ne, id_is_jump, id_is_jump_reg;
    alu_op_t   id_alu_op;

    // ID/EX
    word_t     id_ex_pc, id_ex_rs_val, id_ex_rt_val, id_ex_imm;
    reg_addr_t id_ex_rs, id_ex_rt, id_ex_dst;
    logic      id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_mem_to_reg;
    logic      id_ex_alu_src_imm, id_ex_is_shift, id_ex_is_link;
    alu_op_t   id_ex_alu_op;

    // EX stage and EX/MEM
    fwd_sel_t  fwd_a, fwd_b;
    word_t     ex_a_fwd, ex_b_fwd, alu_a, alu_b, alu_y;
    word_t     ex_mem_pc, ex_mem_alu_res, ex_mem_wdata, mem_result;
    reg_addr_t ex_mem_dst;
    logic      ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_to_reg;
    logic      ex_mem_is_link;

    // MEM/WB
    word_t     mem_wb_pc, mem_wb_alu_res, mem_wb_load, wb_data;
    reg_addr_t mem_wb_dst;
    logic      mem_wb_reg_write, mem_wb_mem_to_reg, mem_wb_is_link;

    // ==============================
    // IF
    // ==============================
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc;
        end
        if (rst) begin
            if_id_instr <= '0;
        end else if (!stall) begin
            if_id_instr <= redirect ? '0 : imem_rdata;   // Squash the fall-through fetch
        end
    end

    // ==============================
    // ID
    // ==============================
    decoder u_decoder (
        .instr        (if_id_instr),
        .reg_write    (id_reg_write),
        .mem_read     (id_mem_read),
        .mem_write    (id_mem_write),
        .mem_to_reg   (id_mem_to_reg),
        .alu_src_imm  (id_alu_src_imm),
        .imm_zero_ext (id_imm_zero_ext),
        .dest_rd      (id_dest_rd),
        .is_shift     (id_is_shift),
        .is_link      (id_is_link),
        .is_branch_eq (id_is_branch_eq),
        .is_branch_ne (id_is_branch_ne),
        .is_jump      (id_is_jump),
        .is_jump_reg  (id_is_jump_reg),
        .alu_op       (id_alu_op)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (id_rs),
        .raddr2 (id_rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (mem_wb_reg_write),
        .waddr  (mem_wb_dst),
        .wdata  (wb_data)
    );

    assign id_rs  = if_id_instr[25:21];
    assign id_rt  = if_id_instr[20:16];
    assign id_dst = id_is_link ? LINK_REG : (id_dest_rd ? if_id_instr[15:11] : id_rt);
    assign id_imm = id_imm_zero_ext ? {16'h0000, if_id_instr[15:0]}
                                    : {{16{if_id_instr[15]}}, if_id_instr[15:0]};

    // EX/MEM result feeds the compare and WB comes through the regfile bypass
    assign id_a = (ex_mem_reg_write && ex_mem_dst != '0 && ex_mem_dst == id_rs) ? mem_result
                                                                                : rf_rdata1;
    assign id_b = (ex_mem_reg_write && ex_mem_dst != '0 && ex_mem_dst == id_rt) ? mem_result
                                                                                : rf_rdata2;

    assign id_pc4        = if_id_pc + 32'd4;
    assign branch_target = id_pc4 + {id_imm[29:0], 2'b00};
    assign jump_target   = {id_pc4[31:28], if_id_instr[25:0], 2'b00};
    assign branch_taken  = (id_is_branch_eq && id_a == id_b) || (id_is_branch_ne && id_a != id_b);
    assign redirect      = branch_taken || id_is_jump || id_is_jump_reg;

    assign pc_next = branch_taken   ? branch_target :
                     id_is_jump     ? jump_target   :
                     id_is_jump_reg ? id_a          : pc + 32'd4;

    always_ff @(posedge clk) begin
        id_ex_pc          <= if_id_pc;
        id_ex_rs_val      <= rf_rdata1;
        id_ex_rt_val      <= rf_rdata2;
        id_ex_imm         <= id_imm;
        id_ex_rs          <= id_rs;
        id_ex_rt          <= id_rt;
        id_ex_dst         <= id_dst;
        id_ex_mem_to_reg  <= id_mem_to_reg;
        id_ex_alu_src_imm <= id_alu_src_imm;
        id_ex_is_shift    <= id_is_shift;
        id_ex_is_link     <= id_is_link;
        id_ex_alu_op      <= id_alu_op;
        if (rst || stall) begin
            id_ex_reg_write <= 1'b0;   // Bubble
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
        end else begin
            id_ex_reg_write <= id_reg_write;
            id_ex_mem_read  <= id_mem_read;
            id_ex_mem_write <= id_mem_write;
        end
    end

    hazard_unit u_hazard (
        .id_rs                   (id_rs),
        .id_rt                   (id_rt),
        .id_uses_branch_operands (id_is_branch_eq || id_is_branch_ne || id_is_jump_reg),
        .ex_rs                   (id_ex_rs),
        .ex_rt                   (id_ex_rt),
        .ex_dst                  (id_ex_dst),
        .ex_reg_write            (id_ex_reg_write),
        .ex_mem_read             (id_ex_mem_read),
        .mem_dst                 (ex_mem_dst),
        .mem_reg_write           (ex_mem_reg_write),
        .mem_mem_read            (ex_mem_mem_read),
        .wb_dst                  (mem_wb_dst),
        .wb_reg_write            (mem_wb_reg_write),
        .fwd_a                   (fwd_a),
        .fwd_b                   (fwd_b),
        .stall                   (stall)
    );

    // ==============================
    // EX
    // ==============================
    assign ex_a_fwd = (fwd_a == FWD_MEM) ? mem_result :
                      (fwd_a == FWD_WB)  ? wb_data    : id_ex_rs_val;
    assign ex_b_fwd = (fwd_b == FWD_MEM) ? mem_result :
                      (fwd_b == FWD_WB)  ? wb_data    : id_ex_rt_val;

    assign alu_a = id_ex_is_shift ? {27'd0, id_ex_imm[10:6]} : ex_a_fwd;   // shamt field
    assign alu_b = id_ex_alu_src_imm ? id_ex_imm : ex_b_fwd;

    alu u_alu (
        .op (id_ex_alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_ff @(posedge clk) begin
        ex_mem_pc         <= id_ex_pc;
        ex_mem_alu_res    <= alu_y;
        ex_mem_wdata      <= ex_b_fwd;   // Store data
        ex_mem_dst        <= id_ex_dst;
        ex_mem_mem_to_reg <= id_ex_mem_to_reg;
        ex_mem_is_link    <= id_ex_is_link;
        if (rst) begin
            ex_mem_reg_write <= 1'b0;
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
        end else begin
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
        end
    end

    // ==============================
    // MEM and WB
    // ==============================
    assign dmem_addr  = ex_mem_alu_res;
    assign dmem_wdata = ex_mem_wdata;
    assign dmem_we    = ex_mem_mem_write;

    // JAL link value must also reach the forwarding paths
    assign mem_result = ex_mem_is_link ? ex_mem_pc + LINK_OFFSET : ex_mem_alu_res;

    always_ff @(posedge clk) begin
        mem_wb_pc         <= ex_mem_pc;
        mem_wb_alu_res    <= ex_mem_alu_res;
        mem_wb_load       <= dmem_rdata;
        mem_wb_dst        <= ex_mem_dst;
        mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
        mem_wb_is_link    <= ex_mem_is_link;
        if (rst) begin
            mem_wb_reg_write <= 1'b0;
        end else begin
            mem_wb_reg_write <= ex_mem_reg_write;
        end
    end

    assign wb_data = mem_wb_mem_to_reg ? mem_wb_load               :
                     mem_wb_is_link    ? mem_wb_pc + LINK_OFFSET   : mem_wb_alu_res;

endmodule

`default_nettype wire

// ==== test/cpu_checker.sv ====
`default_nettype none

module cpu_checker (
    input wire                 clk,
    input wire                 rst,
    input wire cpu_pkg::word_t imem_addr,
    input wire                 dmem_we,
    input wire cpu_pkg::word_t dmem_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // Fetch side
    // ==============================
    fetch_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
        else $error("fetch address %h is not word aligned", imem_addr);

    // ==============================
    // Data side
    // ==============================
    // Pipeline flags clear with reset
    quiet_after_reset: assert property (@(posedge clk) rst |=> !dmem_we)
        else $error("store issued in the cycle after reset");

    we_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(dmem_we))
        else $error("dmem_we is unknown");

    addr_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(dmem_addr))
        else $error("dmem_addr is unknown");

endmodule

`default_nettype wire

// ==== test/cpu_tb.sv ====
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam word_t STORE_BASE   = 32'h0000_0200;
    localparam word_t POISON_ADDR  = 32'h0000_03f0;   // Stores that must be squashed
    localparam int    DRAIN_CYCLES = 8;

    logic  clk;
    logic  rst;
    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    word_t dmem_rdata;
    word_t dmem_wdata;
    logic  dmem_we;

    word_t imem [0:255];
    word_t dmem [0:255];

    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t log_addr [$];
    word_t log_data [$];

    word_t lfsr_state  = 32'h8e03;
    word_t store_ptr   = STORE_BASE;
    int    cycle_count = 0;
    int    cycle_limit = 16;
    int    checks_done = 0;

    cpu_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we)
    );

    bind cpu_core cpu_checker checker_i (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .dmem_we   (dmem_we),
        .dmem_addr (dmem_addr)
    );

    // Both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Data memory write port that logs every store
    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            log_addr.push_back(dmem_addr);
            log_data.push_back(dmem_wdata);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout at %0t: stores still missing after %0d cycles", $time, cycle_limit);
            $display("Something failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t fill_word(input int i);
        return 32'ha5a5_0000 ^ word_t'(i * 4);   // Byte address of the word
    endfunction

    function automatic word_t r_type(input reg_addr_t rs, rt, rd, input logic [4:0] sh,
                                     input funct_t fn);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input reg_addr_t rs, rt,
                                     input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input opcode_t op, input word_t target);
        return {op, target[27:2]};
    endfunction

    function automatic word_t here();
        return word_t'(prog.size() * 4);
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic load_const(input reg_addr_t r, input word_t v);
        emit(i_type(OP_LUI, 5'd0, r, v[31:16]));
        emit(i_type(OP_ORI, r, r, v[15:0]));
    endtask

    task automatic store_at(input reg_addr_t r, input word_t addr);
        emit(i_type(OP_SW, 5'd0, r, addr[15:0]));
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic store_reg(input reg_addr_t r, input word_t exp);
        store_at(r, store_ptr);
        expect_store(store_ptr, exp);
        store_ptr += 4;
    endtask

    task automatic poison();
        store_at(5'd1, POISON_ADDR);
    endtask

    task automatic self_jump();
        emit(j_type(OP_J, here()));
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks_done++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // ==============================
    // Program run
    // ==============================
    task automatic new_program();
        @(posedge clk);
        #1;
        rst = 1'b1;
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        store_ptr = STORE_BASE;
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= fill_word(i);
        end
    endtask

    task automatic run_program(input string name);
        int n;
        n = exp_addr.size();
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        cycle_limit += prog.size() * 4 + 5 + DRAIN_CYCLES + 16;
        repeat (5) @(posedge clk);
        #1;
        log_addr.delete();
        log_data.delete();
        rst = 1'b0;
        while (log_addr.size() < n) @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);   // Late or squashed stores would show here
        check_value({name, " store count"}, word_t'(log_addr.size()), word_t'(n));
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("%s store %0d address", name, i), log_addr[i], exp_addr[i]);
            check_value($sformatf("%s store %0d data", name, i), log_data[i], exp_data[i]);
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic alu_rr(input funct_t fn, input reg_addr_t rs, rt, input word_t exp);
        emit(r_type(rs, rt, 5'd3, 5'd0, fn));
        store_reg(5'd3, exp);
    endtask

    task automatic alu_imm(input opcode_t op, input logic [15:0] imm, input word_t exp);
        emit(i_type(op, 5'd1, 5'd3, imm));
        store_reg(5'd3, exp);
    endtask

    task automatic alu_results();
        word_t       a, b, imm_s, imm_z;
        logic [15:0] imm;
        logic [4:0]  sh;
        new_program();
        a = rand_bits(32);
        b = rand_bits(32);
        load_const(5'd1, a);
        load_const(5'd2, b);
        alu_rr(FN_ADD, 5'd1, 5'd2, a + b);
        alu_rr(FN_ADDU, 5'd1, 5'd2, a + b);
        alu_rr(FN_SUB, 5'd1, 5'd2, a - b);
        alu_rr(FN_SUBU, 5'd2, 5'd1, b - a);
        alu_rr(FN_AND, 5'd1, 5'd2, a & b);
        alu_rr(FN_OR, 5'd1, 5'd2, a | b);
        alu_rr(FN_XOR, 5'd1, 5'd2, a ^ b);
        alu_rr(FN_NOR, 5'd1, 5'd2, ~(a | b));
        alu_rr(FN_SLT, 5'd1, 5'd2, {31'd0, $signed(a) < $signed(b)});
        alu_rr(FN_SLT, 5'd2, 5'd1, {31'd0, $signed(b) < $signed(a)});
        alu_rr(FN_SLTU, 5'd1, 5'd2, {31'd0, a < b});
        alu_rr(FN_SLTU, 5'd2, 5'd1, {31'd0, b < a});
        sh = 5'(rand_bits(5));
        emit(r_type(5'd0, 5'd2, 5'd3, sh, FN_SLL));
        store_reg(5'd3, b << sh);
        emit(r_type(5'd0, 5'd2, 5'd3, sh, FN_SRL));
        store_reg(5'd3, b >> sh);
        emit(r_type(5'd0, 5'd2, 5'd3, sh, FN_SRA));
        store_reg(5'd3, word_t'($signed(b) >>> sh));
        imm   = 16'(rand_bits(16));
        imm_s = {{16{imm[15]}}, imm};
        imm_z = {16'h0000, imm};
        alu_imm(OP_ADDI, imm, a + imm_s);
        alu_imm(OP_ADDIU, imm, a + imm_s);
        alu_imm(OP_SLTI, imm, {31'd0, $signed(a) < $signed(imm_s)});
        alu_imm(OP_SLTIU, imm, {31'd0, a < imm_s});
        alu_imm(OP_ANDI, imm, a & imm_z);
        alu_imm(OP_ORI, imm, a | imm_z);
        alu_imm(OP_XORI, imm, a ^ imm_z);
        alu_imm(OP_LUI, imm, {imm, 16'h0000});
        self_jump();
        run_program("alu");
    endtask

    task automatic forwarding_chains();
        word_t c, d, e6, e7, e8, e9, e10, e11;
        new_program();
        c   = rand_bits(32);
        d   = rand_bits(32);
        e6  = c + d;
        e7  = e6 - c;
        e8  = d ^ e6;
        e9  = e6 | e7;
        e10 = e9 + e9;
        e11 = e8 - e10;
        load_const(5'd4, c);
        load_const(5'd5, d);
        emit(r_type(5'd4, 5'd5, 5'd6, 5'd0, FN_ADDU));
        emit(r_type(5'd6, 5'd4, 5'd7, 5'd0, FN_SUBU));    // Distance 1
        emit(r_type(5'd5, 5'd6, 5'd8, 5'd0, FN_XOR));     // Distance 2 on rt
        emit(r_type(5'd6, 5'd7, 5'd9, 5'd0, FN_OR));      // Distances 3 and 2
        emit(r_type(5'd9, 5'd9, 5'd10, 5'd0, FN_ADDU));
        emit(32'h0000_0000);
        emit(r_type(5'd8, 5'd10, 5'd11, 5'd0, FN_SUBU));
        store_reg(5'd11, e11);   // Store data from EX/MEM
        store_reg(5'd6, e6);
        store_reg(5'd7, e7);
        store_reg(5'd8, e8);
        store_reg(5'd9, e9);
        store_reg(5'd10, e10);
        self_jump();
        run_program("forwarding");
    endtask

    task automatic load_use();
        word_t v1, v2, addend;
        new_program();
        v1      = rand_bits(32);
        v2      = rand_bits(32);
        addend  = rand_bits(32);
        dmem[64] <= v1;          // Address 0x100
        dmem[65] <= v2;
        load_const(5'd12, addend);
        emit(i_type(OP_LW, 5'd0, 5'd13, 16'h0100));
        emit(r_type(5'd13, 5'd12, 5'd14, 5'd0, FN_ADDU));
        store_reg(5'd14, v1 + addend);
        emit(i_type(OP_LW, 5'd0, 5'd15, 16'h0104));
        emit(r_type(5'd12, 5'd15, 5'd16, 5'd0, FN_ADDU));   // Loaded value on rt
        store_reg(5'd16, addend + v2);
        emit(i_type(OP_LW, 5'd0, 5'd17, 16'h0104));
        store_reg(5'd17, v2);
        self_jump();
        run_program("load-use");
    endtask

    task automatic branch_paths();
        word_t a, b;
        new_program();
        a = rand_bits(32);
        b = a ^ (rand_bits(32) | 32'h1);   // Always differs from a
        load_const(5'd1, a);
        load_const(5'd2, a);
        load_const(5'd3, b);
        emit(i_type(OP_BEQ, 5'd1, 5'd2, 16'd1));   // Taken with r2 still in WB
        poison();
        store_reg(5'd1, a);
        emit(i_type(OP_BNE, 5'd1, 5'd2, 16'd1));   // Not taken
        store_reg(5'd3, b);
        emit(i_type(OP_BNE, 5'd1, 5'd3, 16'd1));
        poison();
        emit(i_type(OP_BEQ, 5'd1, 5'd3, 16'd1));
        store_reg(5'd2, a);
        emit(r_type(5'd1, 5'd0, 5'd4, 5'd0, FN_ADDU));
        emit(i_type(OP_BEQ, 5'd4, 5'd2, 16'd1));   // Operand comes from EX
        poison();
        emit(i_type(OP_LW, 5'd0, 5'd5, STORE_BASE[15:0]));
        emit(i_type(OP_BNE, 5'd5, 5'd1, 16'd1));   // Waits for the load
        store_reg(5'd5, a);
        self_jump();
        run_program("branches");
    endtask

    task automatic jump_and_link();
        word_t jal_pc;
        new_program();
        emit(j_type(OP_J, here() + 8));
        poison();
        jal_pc = here();
        emit(j_type(OP_JAL, jal_pc + 16));
        poison();                                // Skipped on return as well
        store_at(5'd31, STORE_BASE + 4);
        self_jump();
        // Subroutine
        store_at(5'd31, STORE_BASE);
        emit(r_type(5'd31, 5'd0, 5'd21, 5'd0, FN_ADDU));
        emit(r_type(5'd21, 5'd0, 5'd0, 5'd0, FN_JR));
        poison();
        expect_store(STORE_BASE, jal_pc + 8);
        expect_store(STORE_BASE + 4, jal_pc + 8);
        run_program("jumps");
    endtask

    initial begin
        rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] <= fill_word(i);
        end
        alu_results();
        forwarding_chains();
        load_use();
        branch_paths();
        jump_and_link();
        if (checks_done > 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("No checks were run");
            $display("Something failed");
            $fatal(1, "empty run");
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/cpu_pkg.sv
design/decoder.sv
design/regfile.sv
design/alu.sv
design/hazard_unit.sv
design/cpu_core.sv
test/cpu_checker.sv
test/cpu_tb.sv

// ==== Makefile ====
TOP = cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f filelist.f --top-module cpu_core
	verilator --lint-only --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
